// ==== instruction_memory/program.mem ====
// 32-bit instruction words in hex, one per line, from address 0
20080005
20090003
01095020
01095822
01096024
01096825
0109702a
ad0a0000
8d0b0000
11090002
21080001
08000003
2129ffff
000a5880
000a6042
3c0d1234
35ad5678
014b7020
01ae7826
00000000
ffffffff
20100007
02108020
0800000b

// ==== build.f ====
common/isa_pkg.sv
common/fetch_pkg.sv
design/fetch_control.sv
design/pc_unit.sv
instruction_memory/instruction_rom.sv
design/if_id_register.sv
design/fetch_stage.sv
verification/tb_fetch_stage.sv

// ==== verification/tb_fetch_stage.sv ====
`timescale 1ns/10ps

module tb_fetch_stage;

  import isa_pkg::*;
  import fetch_pkg::*;

  // Stimulus plus hand-derived expected pc and halt
  typedef struct packed {
    logic [2:0] test;
    logic       rnd;
    logic       stall;
    redirect_t  rd;
    addr_t      exp_pc;
    logic       exp_halt;
  } row_t;

  localparam int    PROG_WORDS   = 24;
  localparam word_t STOP_WORD    = 32'hFFFF_FFFF;
  localparam int    RESET_CYCLES = 3;

  logic      i_clk;
  logic      i_rst;
  logic      i_stall;
  redirect_t i_redirect;
  if_id_t    o_if_id;
  logic      o_halt;

  row_t   rows [$];
  word_t  prog [0:PROG_WORDS-1];
  string  test_name [1:6];
  integer seed;
  int     cycle_count;
  int     cycle_limit;
  int     err_count;
  int     test_err;

  // Reference model state
  addr_t  model_pc;
  logic   model_halted;
  if_id_t exp_if_id;

  fetch_stage i_fetch_stage (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_stall    (i_stall),
    .i_redirect (i_redirect),
    .o_if_id    (o_if_id),
    .o_halt     (o_halt)
  );

  // 8 ns period
  always #4 i_clk = ~i_clk;

  //////////////////////////////
  // Table and model helpers
  //////////////////////////////

  task automatic add_row(input int t, input logic st, input logic br, input int bt,
                         input logic jmp, input int jt, input int pc, input logic hlt);
    row_t r;
    r = '0;
    r.test = t[2:0];
    r.stall = st;
    r.rd = '{branch_taken: br, branch_target: bt, jump: jmp, jump_target: jt};
    r.exp_pc = pc;
    r.exp_halt = hlt;
    rows.push_back(r);
  endtask

  // Random rows with targets below the HALT address
  task automatic add_random_rows(input int count);
    row_t r;
    int   pick;
    for (int i = 0; i < count; i++)
    begin
      r = '0;
      r.test = 3'd6;
      r.rnd = 1'b1;
      r.stall = ($unsigned($random(seed)) % 4) == 0;
      pick = $unsigned($random(seed)) % 10;
      r.rd.branch_taken = (pick == 0) || (pick == 2);
      r.rd.jump = (pick == 1) || (pick == 2);
      r.rd.branch_target = $unsigned($random(seed)) % 20;
      r.rd.jump_target = $unsigned($random(seed)) % 20;
      rows.push_back(r);
    end
  endtask

  task automatic report_fail(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    err_count++;
    test_err++;
  endtask

  // Redirect beats stall and halt
  // HALT word is still delivered
  task automatic step_model(input row_t r);
    word_t word;
    word = (model_pc < PROG_WORDS) ? prog[model_pc] : 'x;
    if (r.rd.jump || r.rd.branch_taken)
    begin
      model_pc = r.rd.jump ? r.rd.jump_target : r.rd.branch_target;
      exp_if_id = '0;
      model_halted = 1'b0;
    end
    else if (!r.stall && !model_halted)
    begin
      exp_if_id = '{instr: word, pc: model_pc, pc_plus1: model_pc + 32'd1};
      if (word == STOP_WORD)
        model_halted = 1'b1;
      else
        model_pc = model_pc + 32'd1;
    end
  endtask

  task automatic check_row(input row_t r, input int idx);
    if (o_if_id !== exp_if_id)
      report_fail($sformatf("row %0d o_if_id pc %0d instr %h, expected pc %0d instr %h",
                            idx, o_if_id.pc, o_if_id.instr, exp_if_id.pc, exp_if_id.instr));
    if (o_halt !== model_halted)
      report_fail($sformatf("row %0d o_halt %b, expected %b", idx, o_halt, model_halted));
    if (!r.rnd && ((o_if_id.pc !== r.exp_pc) || (o_halt !== r.exp_halt)))
      report_fail($sformatf("row %0d pc %0d halt %b, table wants pc %0d halt %b",
                            idx, o_if_id.pc, o_halt, r.exp_pc, r.exp_halt));
  endtask

  // Run limit
  always @(posedge i_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    i_clk = 1'b0;
    i_rst = 1'b0;
    i_stall = 1'b0;
    i_redirect = '0;
    seed = 32'h0817_56da;
    err_count = 0;
    test_err = 0;
    cycle_count = 0;
    test_name = '{"reset and sequential fetch", "stall", "branch flush", "jump priority",
                  "halt", "random mix"};
    $readmemh("instruction_memory/program.mem", prog);
    // test, stall, branch, target, jump, target, then expected pc and halt
    add_row(1, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, 0, 0, 0, 0, 0, 1, 0);
    add_row(1, 0, 0, 0, 0, 0, 2, 0);
    add_row(1, 0, 0, 0, 0, 0, 3, 0);
    add_row(2, 1, 0, 0, 0, 0, 3, 0);
    add_row(2, 1, 0, 0, 0, 0, 3, 0);
    add_row(2, 0, 0, 0, 0, 0, 4, 0);
    add_row(3, 0, 1, 10, 0, 0, 0, 0);
    add_row(3, 0, 0, 0, 0, 0, 10, 0);
    add_row(4, 0, 1, 5, 1, 15, 0, 0);
    add_row(4, 0, 0, 0, 0, 0, 15, 0);
    // Flush beats stall
    add_row(4, 1, 1, 2, 0, 0, 0, 0);
    add_row(4, 0, 0, 0, 0, 0, 2, 0);
    add_row(5, 0, 0, 0, 1, 18, 0, 0);
    add_row(5, 0, 0, 0, 0, 0, 18, 0);
    add_row(5, 0, 0, 0, 0, 0, 19, 0);
    add_row(5, 0, 0, 0, 0, 0, 20, 1);
    add_row(5, 0, 0, 0, 0, 0, 20, 1);
    add_row(5, 0, 0, 0, 0, 0, 20, 1);
    add_row(5, 0, 0, 0, 1, 6, 0, 0);
    add_row(5, 0, 0, 0, 0, 0, 6, 0);
    add_random_rows(40);
    cycle_limit = rows.size() + RESET_CYCLES + 20;
    model_pc = '0;
    model_halted = 1'b0;
    exp_if_id = '0;

    repeat (RESET_CYCLES - 1) @(posedge i_clk);
    @(negedge i_clk);
    if ((o_if_id !== '0) || (o_halt !== 1'b0))
      report_fail("o_if_id or o_halt not cleared during reset");
    @(posedge i_clk);
    i_rst <= 1'b1;
    i_stall <= rows[0].stall;
    i_redirect <= rows[0].rd;

    // Row idx is sampled at the next edge and checked after it
    for (int idx = 0; idx < rows.size(); idx++)
    begin
      @(posedge i_clk);
      i_stall <= (idx + 1 < rows.size()) ? rows[idx+1].stall : 1'b0;
      i_redirect <= (idx + 1 < rows.size()) ? rows[idx+1].rd : '0;
      @(negedge i_clk);
      step_model(rows[idx]);
      check_row(rows[idx], idx);
      if ((idx + 1 == rows.size()) || (rows[idx+1].test != rows[idx].test))
      begin
        $display("Test %0d %s: done, %0d errors", rows[idx].test, test_name[rows[idx].test],
                 test_err);
        test_err = 0;
      end
    end

    $display("Summary: 6 tests, %0d rows, %0d errors", rows.size(), err_count);
    if (err_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule : tb_fetch_stage

// ==== design/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_stall,
  input  fetch_pkg::redirect_t i_redirect,
  output fetch_pkg::if_id_t    o_if_id,
  output logic                 o_halt
);

  import isa_pkg::*;
  import fetch_pkg::*;

  // Control to datapath
  logic    pc_en;
  pc_sel_e pc_sel;
  logic    ifid_hold;
  logic    ifid_clear;

  // Datapath
  addr_t  pc;
  addr_t  pc_plus1;
  word_t  instr;
  logic   is_halt;
  if_id_t if_id_next;

  //////////////////////////////
  // Control
  //////////////////////////////

  fetch_control u_fetch_control (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_stall        (i_stall),
    .i_branch_taken (i_redirect.branch_taken),
    .i_jump         (i_redirect.jump),
    .i_is_halt      (is_halt),
    .o_pc_en        (pc_en),
    .o_pc_sel       (pc_sel),
    .o_ifid_hold    (ifid_hold),
    .o_ifid_clear   (ifid_clear),
    .o_halt         (o_halt)
  );

  //////////////////////////////
  // PC, ROM and IF/ID
  //////////////////////////////

  pc_unit u_pc_unit (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_pc_en         (pc_en),
    .i_pc_sel        (pc_sel),
    .i_branch_target (i_redirect.branch_target),
    .i_jump_target   (i_redirect.jump_target),
    .o_pc            (pc),
    .o_pc_plus1      (pc_plus1)
  );

  instruction_rom u_instruction_rom (
    .i_addr    (pc),
    .o_word    (instr),
    .o_is_halt (is_halt)
  );

  // Entry handed to decode
  assign if_id_next = '{instr: instr, pc: pc, pc_plus1: pc_plus1};

  if_id_register u_if_id_register (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_hold  (ifid_hold),
    .i_clear (ifid_clear),
    .i_if_id (if_id_next),
    .o_if_id (o_if_id)
  );

endmodule : fetch_stage

// ==== design/if_id_register.sv ====
`timescale 1ns/10ps

module if_id_register (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_hold,
  input  logic              i_clear,
  input  fetch_pkg::if_id_t i_if_id,
  output fetch_pkg::if_id_t o_if_id
);

  //////////////////////////////
  // Fetch to decode register
  //////////////////////////////

  // Priority is clear, then hold, then load
  always_ff @(posedge i_clk)
  begin
    if (!i_rst)
    begin
      // Decode sees a null entry out of reset
      o_if_id <= '0;
    end
    else if (i_clear)
    begin
      // Flush on redirect
      // wins over a stall
      o_if_id <= '0;
    end
    else if (i_hold)
    begin
      // Stall or halted
      o_if_id <= o_if_id;
    end
    else
    begin
      // Normal fetch
      o_if_id <= i_if_id;
    end
  end

endmodule : if_id_register

// ==== instruction_memory/instruction_rom.sv ====
`timescale 1ns/10ps

module instruction_rom (
  input  isa_pkg::addr_t i_addr,
  output isa_pkg::word_t o_word,
  output logic           o_is_halt
);

  import isa_pkg::*;
  import fetch_pkg::*;

  // ROM array
  word_t mem [0:ROM_DEPTH-1];

  logic [ROM_ADDR_W-1:0] rom_idx;

  //////////////////////////////
  // Program image
  //////////////////////////////

  // Contents come only from the hex file
  initial
  begin
    $readmemh(ROM_INIT_FILE, mem);
  end

  //////////////////////////////
  // Asynchronous read
  //////////////////////////////

  // Upper PC bits wrap onto the ROM
  assign rom_idx = i_addr[ROM_ADDR_W-1:0];

  // Zero-cycle read at the current PC
  assign o_word = mem[rom_idx];

  // HALT detect
  assign o_is_halt = (o_word == HALT_WORD);

endmodule : instruction_rom

// ==== design/pc_unit.sv ====
`timescale 1ns/10ps

module pc_unit (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_pc_en,
  input  fetch_pkg::pc_sel_e i_pc_sel,
  input  isa_pkg::addr_t     i_branch_target,
  input  isa_pkg::addr_t     i_jump_target,
  output isa_pkg::addr_t     o_pc,
  output isa_pkg::addr_t     o_pc_plus1
);

  import isa_pkg::*;
  import fetch_pkg::*;

  addr_t pc;
  addr_t pc_next;
  logic  pc_load;

  // Word incrementer
  assign o_pc_plus1 = pc + PC_STEP;

  //////////////////////////////
  // Next-PC mux
  //////////////////////////////

  always_comb
  begin
    case (i_pc_sel)
      PC_BRANCH:
      begin
        pc_next = i_branch_target;
      end
      PC_JUMP:
      begin
        pc_next = i_jump_target;
      end
      default:
      begin
        pc_next = o_pc_plus1;
      end
    endcase
  end

  // Redirects load even when stalled or halted
  assign pc_load = i_pc_en | (i_pc_sel != PC_SEQ);

  // PC register
  always_ff @(posedge i_clk)
  begin
    if (!i_rst)
    begin
      pc <= '0;
    end
    else if (pc_load)
    begin
      pc <= pc_next;
    end
  end

  assign o_pc = pc;

endmodule : pc_unit

// ==== design/fetch_control.sv ====
`timescale 1ns/10ps

module fetch_control (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_stall,
  input  logic               i_branch_taken,
  input  logic               i_jump,
  input  logic               i_is_halt,
  output logic               o_pc_en,
  output fetch_pkg::pc_sel_e o_pc_sel,
  output logic               o_ifid_hold,
  output logic               o_ifid_clear,
  output logic               o_halt
);

  import fetch_pkg::*;

  fetch_state_e state;
  fetch_state_e state_next;
  logic         redirect;

  // Any redirect flushes IF/ID
  assign redirect = i_jump | i_branch_taken;

  //////////////////////////////
  // Per-cycle decisions
  //////////////////////////////

  // Jump first, then taken branch
  assign o_pc_sel = i_jump         ? PC_JUMP   :
                    i_branch_taken ? PC_BRANCH :
                                     PC_SEQ;

  assign o_ifid_clear = redirect;

  // Freeze decode input on stall or while halted
  // a flush overrides both
  assign o_ifid_hold = ~redirect & (i_stall | (state == ST_HALTED));

  // Sequential advance only when running freely
  // HALT word stops the PC but still loads IF/ID
  assign o_pc_en = ~redirect & ~i_stall & (state == ST_RUN) & ~i_is_halt;

  assign o_halt = (state == ST_HALTED);

  //////////////////////////////
  // Run / halted state
  //////////////////////////////

  always_comb
  begin
    state_next = state;
    if (redirect)
    begin
      // Redirect restarts fetch
      state_next = ST_RUN;
    end
    else if (i_stall)
    begin
      state_next = state;
    end
    else if ((state == ST_RUN) && i_is_halt)
    begin
      state_next = ST_HALTED;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (!i_rst)
    begin
      state <= ST_RUN;
    end
    else
    begin
      state <= state_next;
    end
  end

endmodule : fetch_control

// ==== common/fetch_pkg.sv ====
//////////////////////////////
// Fetch stage definitions
//////////////////////////////

package fetch_pkg;

  import isa_pkg::*;

  // Instruction ROM geometry
  localparam int ROM_DEPTH  = 2048;
  localparam int ROM_ADDR_W = 11;

  // Program image loaded at start
  localparam string ROM_INIT_FILE = "instruction_memory/program.mem";

  // Redirect request from later stages
  // Jump wins over a taken branch
  typedef struct packed {
    logic  branch_taken;
    addr_t branch_target;
    logic  jump;
    addr_t jump_target;
  } redirect_t;

  // IF/ID pipeline register content
  typedef struct packed {
    word_t instr;
    addr_t pc;
    addr_t pc_plus1;
  } if_id_t;

  // Next-PC source
  typedef enum logic [1:0] {
    PC_SEQ    = 2'd0,
    PC_BRANCH = 2'd1,
    PC_JUMP   = 2'd2
  } pc_sel_e;

  // Fetch control state
  typedef enum logic {
    ST_RUN    = 1'b0,
    ST_HALTED = 1'b1
  } fetch_state_e;

endpackage : fetch_pkg

// ==== common/isa_pkg.sv ====
//////////////////////////////
// Instruction-set definitions
//////////////////////////////

package isa_pkg;

  // Datapath widths
  localparam int WORD_W = 32;
  localparam int ADDR_W = 32;

  // One instruction word
  typedef logic [WORD_W-1:0] word_t;

  // Word address as held in the PC
  typedef logic [ADDR_W-1:0] addr_t;

  // All ones stops instruction fetch
  localparam word_t HALT_WORD = '1;

  // Word addressing
  // so the next instruction is one address up
  localparam addr_t PC_STEP = addr_t'(1);

endpackage : isa_pkg
